// File: compile.f
verilog/pe_periph_pkg.sv
verilog/pe_bus_decode.sv
verilog/pe_rtc.sv
verilog/pe_plic.sv
verilog/pe_periph_top.sv
tests/pe_periph_chk.sv
tests/tb_pe_periph.sv

// File: Bender.yml
package:
  name: pe_periph

sources:
  - verilog/pe_periph_pkg.sv
  - verilog/pe_bus_decode.sv
  - verilog/pe_rtc.sv
  - verilog/pe_plic.sv
  - verilog/pe_periph_top.sv
  - target: test
    files:
      - tests/pe_periph_chk.sv
      - tests/tb_pe_periph.sv

// File: tests/tb_pe_periph.sv
`default_nettype none

module tb_pe_periph;

    timeunit 1ns;
    timeprecision 1ps;

    import pe_periph_pkg::*;

    localparam int unsigned NUM_XFERS = 400;
    localparam int unsigned CYC_LIMIT = NUM_XFERS * 4 + 200;
    localparam int unsigned MEM_WORDS = 256;
    localparam int unsigned SEED      = 59632;

    logic                clk_i;
    logic                rst_ni;
    logic                wb_cyc_i;
    logic                wb_stb_i;
    logic                wb_we_i;
    logic [SEL_W-1:0]    wb_sel_i;
    logic [ADDR_W-1:0]   wb_adr_i;
    logic [DATA_W-1:0]   wb_dat_i;
    logic                wb_ack_o;
    logic [DATA_W-1:0]   wb_dat_o;
    logic                dmem_en_o;
    logic [SEL_W-1:0]    dmem_we_o;
    logic [OFFSET_W-1:0] dmem_addr_o;
    logic [DATA_W-1:0]   dmem_data_o;
    logic [DATA_W-1:0]   dmem_data_i = '0;
    logic                ext_irq_i;
    logic                mti_o;
    logic                mei_o;

    // Memory behind the dmem port and its reference copy
    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [DATA_W-1:0] model_mem [MEM_WORDS];

    // Reference state for timer and interrupt controller
    logic [63:0] cyc_cnt;
    logic [63:0] m_cmp;
    logic        m_en;
    logic        m_pend;
    logic        m_insvc;
    int unsigned wd_cnt = 0;

    pe_periph_top i_dut (
        .clk_i       (clk_i      ),
        .rst_ni      (rst_ni     ),
        .wb_cyc_i    (wb_cyc_i   ),
        .wb_stb_i    (wb_stb_i   ),
        .wb_we_i     (wb_we_i    ),
        .wb_sel_i    (wb_sel_i   ),
        .wb_adr_i    (wb_adr_i   ),
        .wb_dat_i    (wb_dat_i   ),
        .wb_ack_o    (wb_ack_o   ),
        .wb_dat_o    (wb_dat_o   ),
        .dmem_en_o   (dmem_en_o  ),
        .dmem_we_o   (dmem_we_o  ),
        .dmem_addr_o (dmem_addr_o),
        .dmem_data_o (dmem_data_o),
        .dmem_data_i (dmem_data_i),
        .ext_irq_i   (ext_irq_i  ),
        .mti_o       (mti_o      ),
        .mei_o       (mei_o      )
    );

    bind pe_periph_top pe_periph_chk i_chk (
        .clk_i     (clk_i    ),
        .rst_ni    (rst_ni   ),
        .cyc_i     (wb_cyc_i ),
        .stb_i     (wb_stb_i ),
        .ack_i     (wb_ack_o ),
        .dmem_en_i (dmem_en_o),
        .rtc_en_i  (rtc_en   ),
        .plic_en_i (plic_en  )
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////////////////////////
    // Data memory with one-cycle synchronous read
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        if (dmem_en_o) begin
            dmem_data_i <= mem[dmem_addr_o[9:2]];
            for (int b = 0; b < SEL_W; b++) begin
                if (dmem_we_o[b]) begin
                    mem[dmem_addr_o[9:2]][8*b +: 8] <= dmem_data_o[8*b +: 8];
                end
            end
        end
    end

    // Model of mtime counting edges since reset release
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cyc_cnt <= '0;
        end else begin
            cyc_cnt <= cyc_cnt + 64'd1;
        end
    end

    always @(posedge clk_i) begin
        wd_cnt <= wd_cnt + 1;
        if (wd_cnt >= CYC_LIMIT) begin
            $display("Timeout: the run went past %0d cycles", CYC_LIMIT);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] apply_sel(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  sel);
        logic [31:0] mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic logic [31:0] reg_addr(input logic [7:0] region, input logic [1:0] widx);
        logic [31:0] rnd;
        rnd = $urandom;
        return {region, rnd[23:4], widx, 2'b00};
    endfunction

    function automatic logic [31:0] mem_addr(input logic [7:0] idx);
        logic [31:0] rnd;
        rnd = $urandom;
        return {REGION_DMEM, rnd[23:10], idx, 2'b00};
    endfunction

    function automatic logic [31:0] unmapped_addr();
        logic [31:0] rnd;
        rnd = $urandom;
        while (rnd[31:24] inside {REGION_DMEM, REGION_RTC, REGION_PLIC}) begin
            rnd = $urandom;
        end
        return rnd;
    endfunction

    // Request gateway on an edge without a PLIC access
    function automatic void gateway_idle();
        if (ext_irq_i && !m_insvc) begin
            m_pend = 1'b1;
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: actual 0x%h expected 0x%h", name, actual, expected);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic wait_cycles(input int unsigned n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
            gateway_idle();
        end
    endtask

    // One Wishbone transfer entered 1 ns after a rising edge
    task automatic bus_xfer(input logic we, input logic [3:0] sel,
                            input logic [31:0] adr, input logic [31:0] dat);
        logic [7:0]  region;
        logic [1:0]  widx;
        logic [31:0] exp_rd;
        logic        claim_ok;
        int unsigned lat;
        region   = adr[31:24];
        widx     = adr[3:2];
        exp_rd   = '0;
        claim_ok = (region == REGION_PLIC) && !we && (widx == PLIC_CLAIM) && m_pend && m_en;

        // Read word comes from the state before the start edge
        case (region)
            REGION_DMEM: begin
                exp_rd = model_mem[adr[9:2]];
                if (we) begin
                    model_mem[adr[9:2]] = apply_sel(model_mem[adr[9:2]], dat, sel);
                end
            end
            REGION_RTC: begin
                case (widx)
                    RTC_MTIME_LO:    exp_rd = cyc_cnt[31:0];
                    RTC_MTIME_HI:    exp_rd = cyc_cnt[63:32];
                    RTC_MTIMECMP_LO: exp_rd = m_cmp[31:0];
                    default:         exp_rd = m_cmp[63:32];
                endcase
                if (we && widx == RTC_MTIMECMP_LO) begin
                    m_cmp[31:0] = apply_sel(m_cmp[31:0], dat, sel);
                end
                if (we && widx == RTC_MTIMECMP_HI) begin
                    m_cmp[63:32] = apply_sel(m_cmp[63:32], dat, sel);
                end
            end
            REGION_PLIC: begin
                case (widx)
                    PLIC_ENABLE:  exp_rd = {31'b0, m_en};
                    PLIC_PENDING: exp_rd = {31'b0, m_pend};
                    PLIC_CLAIM:   exp_rd = claim_ok ? PLIC_SRC_ID : '0;
                    default:      exp_rd = '0;
                endcase
                if (we && widx == PLIC_ENABLE) begin
                    m_en = dat[0];
                end
            end
            default: begin
                exp_rd = '0;
            end
        endcase

        // Gateway at the start edge
        if (claim_ok) begin
            m_pend  = 1'b0;
            m_insvc = 1'b1;
        end else begin
            gateway_idle();
            if (region == REGION_PLIC && we && widx == PLIC_CLAIM) begin
                m_insvc = 1'b0;
            end
        end

        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_sel_i = sel;
        wb_adr_i = adr;
        wb_dat_i = dat;

        // Memory port request during the start cycle
        #1;
        check_value("dmem_en_o", dmem_en_o, region == REGION_DMEM);
        check_value("dmem_we_o", dmem_we_o, (region == REGION_DMEM && we) ? sel : 4'h0);
        if (region == REGION_DMEM) begin
            check_value("dmem_addr_o", dmem_addr_o, adr[23:0]);
            check_value("dmem_data_o", dmem_data_o, dat);
        end

        lat = 0;
        do begin
            @(posedge clk_i);
            #1;
            lat++;
        end while (!wb_ack_o);
        check_value("wb_ack_o latency", lat, 1);
        if (!we) begin
            check_value("wb_dat_o", wb_dat_o, exp_rd);
        end
        check_value("mei_o", mei_o, m_pend && m_en);

        // Request stays up over the acknowledge edge
        @(posedge clk_i);
        #1;
        gateway_idle();
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [7:0]        idx_q[$];
        logic [7:0]        idx;
        logic [63:0]       target;
        logic [31:0]       adr;
        logic [DATA_W-1:0] fill;
        void'($urandom(SEED));
        rst_ni    = 1'b0;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_sel_i  = '0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        ext_irq_i = 1'b0;
        m_cmp     = '1;
        m_en      = 1'b0;
        m_pend    = 1'b0;
        m_insvc   = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            fill         = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3 ^ i[7:0]};
            mem[i]       <= fill;
            model_mem[i] = fill;
        end
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        wait_cycles(2);

        // Memory writes with byte selects and read back
        for (int i = 0; i < 24; i++) begin
            idx = 8'($urandom);
            idx_q.push_back(idx);
            bus_xfer(1'b1, 4'($urandom), mem_addr(idx), $urandom);
        end
        foreach (idx_q[k]) begin
            bus_xfer(1'b0, 4'hf, mem_addr(idx_q[k]), '0);
        end

        // Timer reads and compare register writes
        bus_xfer(1'b0, 4'hf, reg_addr(REGION_RTC, RTC_MTIME_LO), '0);
        bus_xfer(1'b0, 4'hf, reg_addr(REGION_RTC, RTC_MTIME_HI), '0);
        bus_xfer(1'b1, 4'hf, reg_addr(REGION_RTC, RTC_MTIME_LO), $urandom);
        bus_xfer(1'b0, 4'hf, reg_addr(REGION_RTC, RTC_MTIME_LO), '0);
        for (int i = 0; i < 4; i++) begin
            adr = reg_addr(REGION_RTC, ($urandom % 2) ? RTC_MTIMECMP_HI : RTC_MTIMECMP_LO);
            bus_xfer(1'b1, 4'($urandom), adr, $urandom);
            bus_xfer(1'b0, 4'hf, reg_addr(REGION_RTC, RTC_MTIMECMP_LO), '0);
            bus_xfer(1'b0, 4'hf, reg_addr(REGION_RTC, RTC_MTIMECMP_HI), '0);
        end

        // Timer interrupt a short distance ahead
        bus_xfer(1'b1, 4'hf, reg_addr(REGION_RTC, RTC_MTIMECMP_LO), 32'hffff_ffff);
        bus_xfer(1'b1, 4'hf, reg_addr(REGION_RTC, RTC_MTIMECMP_HI), 32'h0);
        target = cyc_cnt + 64'd10 + 64'($urandom % 20);
        bus_xfer(1'b1, 4'hf, reg_addr(REGION_RTC, RTC_MTIMECMP_LO), target[31:0]);
        while (cyc_cnt < target + 64'd4) begin
            check_value("mti_o", mti_o, (cyc_cnt - 64'd1) >= target);
            wait_cycles(1);
        end
        check_value("mti_o", mti_o, 1);

        // Interrupt controller claim and complete
        for (int i = 0; i < 8; i++) begin
            bus_xfer(1'b1, 4'hf, reg_addr(REGION_PLIC, PLIC_ENABLE), $urandom % 2);
            ext_irq_i = 1'b1;
            wait_cycles(2);
            bus_xfer(1'b0, 4'hf, reg_addr(REGION_PLIC, PLIC_PENDING), '0);
            bus_xfer(1'b0, 4'hf, reg_addr(REGION_PLIC, PLIC_CLAIM), '0);
            ext_irq_i = 1'($urandom % 2);
            bus_xfer(1'b0, 4'hf, reg_addr(REGION_PLIC, PLIC_PENDING), '0);
            bus_xfer(1'b0, 4'hf, reg_addr(REGION_PLIC, PLIC_CLAIM), '0);
            bus_xfer(1'b1, 4'hf, reg_addr(REGION_PLIC, PLIC_CLAIM), '0);
            ext_irq_i = 1'b0;
            wait_cycles(1);
        end

        // Unmapped regions and a check that nothing moved
        for (int i = 0; i < 10; i++) begin
            bus_xfer(1'b1, 4'($urandom), unmapped_addr(), $urandom);
            bus_xfer(1'b0, 4'hf, unmapped_addr(), '0);
        end
        bus_xfer(1'b0, 4'hf, reg_addr(REGION_RTC, RTC_MTIMECMP_LO), '0);
        bus_xfer(1'b0, 4'hf, reg_addr(REGION_RTC, RTC_MTIMECMP_HI), '0);
        bus_xfer(1'b0, 4'hf, reg_addr(REGION_PLIC, PLIC_ENABLE), '0);
        bus_xfer(1'b0, 4'hf, reg_addr(REGION_PLIC, PLIC_PENDING), '0);
        bus_xfer(1'b0, 4'hf, mem_addr(idx_q[0]), '0);
        bus_xfer(1'b0, 4'hf, mem_addr(idx_q[1]), '0);
        foreach (mem[w]) begin
            check_value("mem", mem[w], model_mem[w]);
        end

        // Mixed traffic across all regions
        for (int i = 0; i < 180; i++) begin
            case ($urandom % 4)
                0:       adr = mem_addr(8'($urandom));
                1:       adr = reg_addr(REGION_RTC, 2'($urandom));
                2:       adr = reg_addr(REGION_PLIC, 2'($urandom));
                default: adr = unmapped_addr();
            endcase
            ext_irq_i = (($urandom % 4) == 0);
            bus_xfer(1'($urandom), 4'($urandom), adr, $urandom);
        end

        if (i_dut.i_chk.fail_cnt != 0) begin
            $display("Bus protocol assertions failed %0d times", i_dut.i_chk.fail_cnt);
            $display("TB FAILED");
            $fatal(1);
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/pe_periph_chk.sv
`default_nettype none

module pe_periph_chk (
    input logic clk_i,
    input logic rst_ni,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic dmem_en_i,
    input logic rtc_en_i,
    input logic plic_en_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;
    logic        start;

    // Same start condition as the decoder sees it
    assign start = cyc_i && stb_i && !ack_i;

    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ack_i |-> (cyc_i && stb_i))
        else begin
            fail_cnt++;
            $error("ack raised without cyc and stb");
        end

    ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ack_i |=> !ack_i)
        else begin
            fail_cnt++;
            $error("ack held for two cycles");
        end

    ack_after_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
        start |=> ack_i)
        else begin
            fail_cnt++;
            $error("transfer start not acknowledged in the next cycle");
        end

    strobe_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({dmem_en_i, rtc_en_i, plic_en_i}))
        else begin
            fail_cnt++;
            $error("more than one region strobe active");
        end

endmodule

`default_nettype wire

// File: verilog/pe_periph_top.sv
`default_nettype none

module pe_periph_top (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,

    // Wishbone classic slave
    input  logic                                 wb_cyc_i,
    input  logic                                 wb_stb_i,
    input  logic                                 wb_we_i,
    input  logic [pe_periph_pkg::SEL_W-1:0]      wb_sel_i,
    input  logic [pe_periph_pkg::ADDR_W-1:0]     wb_adr_i,
    input  logic [pe_periph_pkg::DATA_W-1:0]     wb_dat_i,
    output logic                                 wb_ack_o,
    output logic [pe_periph_pkg::DATA_W-1:0]     wb_dat_o,

    // External data memory
    output logic                                 dmem_en_o,
    output logic [pe_periph_pkg::SEL_W-1:0]      dmem_we_o,
    output logic [pe_periph_pkg::OFFSET_W-1:0]   dmem_addr_o,
    output logic [pe_periph_pkg::DATA_W-1:0]     dmem_data_o,
    input  logic [pe_periph_pkg::DATA_W-1:0]     dmem_data_i,

    // Interrupts
    input  logic                                 ext_irq_i,
    output logic                                 mti_o,
    output logic                                 mei_o
);

    import pe_periph_pkg::*;

    logic              rtc_en;
    logic              plic_en;
    logic [DATA_W-1:0] rtc_data;
    logic [DATA_W-1:0] plic_data;

    //////////////////////////////////////////////////////////////////////
    // Address decode and read return
    //////////////////////////////////////////////////////////////////////

    pe_bus_decode i_decode (
        .clk_i       (clk_i      ),
        .rst_ni      (rst_ni     ),
        .wb_cyc_i    (wb_cyc_i   ),
        .wb_stb_i    (wb_stb_i   ),
        .wb_we_i     (wb_we_i    ),
        .wb_sel_i    (wb_sel_i   ),
        .wb_adr_i    (wb_adr_i   ),
        .wb_dat_i    (wb_dat_i   ),
        .wb_ack_o    (wb_ack_o   ),
        .wb_dat_o    (wb_dat_o   ),
        .dmem_en_o   (dmem_en_o  ),
        .dmem_we_o   (dmem_we_o  ),
        .dmem_addr_o (dmem_addr_o),
        .dmem_data_o (dmem_data_o),
        .dmem_data_i (dmem_data_i),
        .rtc_data_i  (rtc_data   ),
        .plic_data_i (plic_data  ),
        .rtc_en_o    (rtc_en     ),
        .plic_en_o   (plic_en    )
    );

    //////////////////////////////////////////////////////////////////////
    // Timer and interrupt controller
    //////////////////////////////////////////////////////////////////////

    pe_rtc i_rtc (
        .clk_i  (clk_i   ),
        .rst_ni (rst_ni  ),
        .en_i   (rtc_en  ),
        .we_i   (wb_we_i ),
        .sel_i  (wb_sel_i),
        .addr_i (wb_adr_i),
        .data_i (wb_dat_i),
        .data_o (rtc_data),
        .mti_o  (mti_o   )
    );

    // The external line stands in for the network interface interrupt
    pe_plic i_plic (
        .clk_i  (clk_i    ),
        .rst_ni (rst_ni   ),
        .en_i   (plic_en  ),
        .we_i   (wb_we_i  ),
        .addr_i (wb_adr_i ),
        .data_i (wb_dat_i ),
        .irq_i  (ext_irq_i),
        .data_o (plic_data),
        .mei_o  (mei_o    )
    );

endmodule

`default_nettype wire

// File: verilog/pe_plic.sv
`default_nettype none

module pe_plic (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 en_i,
    input  logic                                 we_i,
    input  pe_periph_pkg::bus_addr_u             addr_i,
    input  logic [pe_periph_pkg::DATA_W-1:0]     data_i,
    input  logic                                 irq_i,
    output logic [pe_periph_pkg::DATA_W-1:0]     data_o,
    output logic                                 mei_o
);

    import pe_periph_pkg::*;

    logic enable_q;
    logic pending_q;
    logic in_service_q;
    logic rd_en;
    logic claim_ok;
    logic complete;

    assign rd_en    = en_i && !we_i;
    // A claim only succeeds on an enabled, pending source
    assign claim_ok = rd_en && (addr_i.reg_view.word_idx == PLIC_CLAIM)
                      && pending_q && enable_q;
    assign complete = en_i && we_i && (addr_i.reg_view.word_idx == PLIC_CLAIM);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q     <= 1'b0;
            pending_q    <= 1'b0;
            in_service_q <= 1'b0;
        end else begin
            if (en_i && we_i && (addr_i.reg_view.word_idx == PLIC_ENABLE)) begin
                enable_q <= data_i[0];
            end

            // Claim beats a new request in the same cycle
            if (claim_ok) begin
                pending_q <= 1'b0;
            end else if (irq_i && !in_service_q) begin
                pending_q <= 1'b1;
            end

            if (claim_ok) begin
                in_service_q <= 1'b1;
            end else if (complete) begin
                in_service_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            case (addr_i.reg_view.word_idx)
                PLIC_ENABLE:  data_o <= {{(DATA_W-1){1'b0}}, enable_q};
                PLIC_PENDING: data_o <= {{(DATA_W-1){1'b0}}, pending_q};
                PLIC_CLAIM:   data_o <= claim_ok ? PLIC_SRC_ID : '0;
                default:      data_o <= '0;
            endcase
        end
    end

    assign mei_o = pending_q && enable_q;

endmodule

`default_nettype wire

// File: verilog/pe_rtc.sv
`default_nettype none

module pe_rtc (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 en_i,
    input  logic                                 we_i,
    input  logic [pe_periph_pkg::SEL_W-1:0]      sel_i,
    input  pe_periph_pkg::bus_addr_u             addr_i,
    input  logic [pe_periph_pkg::DATA_W-1:0]     data_i,
    output logic [pe_periph_pkg::DATA_W-1:0]     data_o,
    output logic                                 mti_o
);

    import pe_periph_pkg::*;

    logic [TIME_W-1:0] mtime_q;
    logic [TIME_W-1:0] mtimecmp_q;
    logic              wr_cmp_lo;
    logic              wr_cmp_hi;
    logic              mti_q;

    // Replace only the bytes flagged in sel
    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [SEL_W-1:0]  sel
    );
        logic [DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < SEL_W; b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Counter and compare register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    assign wr_cmp_lo = en_i && we_i && (addr_i.reg_view.word_idx == RTC_MTIMECMP_LO);
    assign wr_cmp_hi = en_i && we_i && (addr_i.reg_view.word_idx == RTC_MTIMECMP_HI);

    // Starts at all ones so no timer interrupt fires out of reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtimecmp_q <= '1;
        end else if (wr_cmp_lo) begin
            mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], data_i, sel_i);
        end else if (wr_cmp_hi) begin
            mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], data_i, sel_i);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mti_q <= 1'b0;
        end else begin
            mti_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign mti_o = mti_q;

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            case (addr_i.reg_view.word_idx)
                RTC_MTIME_LO:    data_o <= mtime_q[31:0];
                RTC_MTIME_HI:    data_o <= mtime_q[63:32];
                RTC_MTIMECMP_LO: data_o <= mtimecmp_q[31:0];
                RTC_MTIMECMP_HI: data_o <= mtimecmp_q[63:32];
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/pe_bus_decode.sv
`default_nettype none

module pe_bus_decode (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,

    // Wishbone classic slave
    input  logic                                 wb_cyc_i,
    input  logic                                 wb_stb_i,
    input  logic                                 wb_we_i,
    input  logic [pe_periph_pkg::SEL_W-1:0]      wb_sel_i,
    input  pe_periph_pkg::bus_addr_u             wb_adr_i,
    input  logic [pe_periph_pkg::DATA_W-1:0]     wb_dat_i,
    output logic                                 wb_ack_o,
    output logic [pe_periph_pkg::DATA_W-1:0]     wb_dat_o,

    // External data memory
    output logic                                 dmem_en_o,
    output logic [pe_periph_pkg::SEL_W-1:0]      dmem_we_o,
    output logic [pe_periph_pkg::OFFSET_W-1:0]   dmem_addr_o,
    output logic [pe_periph_pkg::DATA_W-1:0]     dmem_data_o,
    input  logic [pe_periph_pkg::DATA_W-1:0]     dmem_data_i,

    // Peripheral strobes and registered read words
    input  logic [pe_periph_pkg::DATA_W-1:0]     rtc_data_i,
    input  logic [pe_periph_pkg::DATA_W-1:0]     plic_data_i,
    output logic                                 rtc_en_o,
    output logic                                 plic_en_o
);

    import pe_periph_pkg::*;

    logic xfer_start;
    logic hit_dmem;
    logic hit_rtc;
    logic hit_plic;
    logic ack_q;
    logic dmem_sel_q;
    logic rtc_sel_q;
    logic plic_sel_q;

    //////////////////////////////////////////////////////////////////////
    // Transfer start and region decode
    //////////////////////////////////////////////////////////////////////

    // New transfer only while the previous one is not being acked
    assign xfer_start = wb_cyc_i && wb_stb_i && !ack_q;

    assign hit_dmem = (wb_adr_i.region_view.region == REGION_DMEM);
    assign hit_rtc  = (wb_adr_i.region_view.region == REGION_RTC);
    assign hit_plic = (wb_adr_i.region_view.region == REGION_PLIC);

    assign dmem_en_o = xfer_start && hit_dmem;
    assign rtc_en_o  = xfer_start && hit_rtc;
    assign plic_en_o = xfer_start && hit_plic;

    // Byte enables only on a write into the memory region
    assign dmem_we_o   = (dmem_en_o && wb_we_i) ? wb_sel_i : '0;
    assign dmem_addr_o = wb_adr_i.region_view.offset;
    assign dmem_data_o = wb_dat_i;

    //////////////////////////////////////////////////////////////////////
    // Acknowledge and delayed region select
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ack_q      <= 1'b0;
            dmem_sel_q <= 1'b0;
            rtc_sel_q  <= 1'b0;
            plic_sel_q <= 1'b0;
        end else begin
            ack_q      <= xfer_start;
            dmem_sel_q <= dmem_en_o;
            rtc_sel_q  <= rtc_en_o;
            plic_sel_q <= plic_en_o;
        end
    end

    assign wb_ack_o = ack_q;

    // Unmapped regions fall through to zero
    always_comb begin
        if (dmem_sel_q) begin
            wb_dat_o = dmem_data_i;
        end else if (rtc_sel_q) begin
            wb_dat_o = rtc_data_i;
        end else if (plic_sel_q) begin
            wb_dat_o = plic_data_i;
        end else begin
            wb_dat_o = '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pe_periph_pkg.sv
`default_nettype none

package pe_periph_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned ADDR_W   = 32;
    localparam int unsigned DATA_W   = 32;
    localparam int unsigned SEL_W    = 4;
    localparam int unsigned REGION_W = 8;
    localparam int unsigned OFFSET_W = 24;

    // Machine timer counter width
    localparam int unsigned TIME_W   = 64;

    //////////////////////////////////////////////////////////////////////
    // Memory map by top address byte
    //////////////////////////////////////////////////////////////////////

    localparam logic [REGION_W-1:0] REGION_DMEM = 8'h01;
    localparam logic [REGION_W-1:0] REGION_RTC  = 8'h02;
    localparam logic [REGION_W-1:0] REGION_PLIC = 8'h04;

    //////////////////////////////////////////////////////////////////////
    // Register word indices in address bits 3:2
    //////////////////////////////////////////////////////////////////////

    localparam logic [1:0] RTC_MTIME_LO    = 2'd0;
    localparam logic [1:0] RTC_MTIME_HI    = 2'd1;
    localparam logic [1:0] RTC_MTIMECMP_LO = 2'd2;
    localparam logic [1:0] RTC_MTIMECMP_HI = 2'd3;

    localparam logic [1:0] PLIC_ENABLE  = 2'd0;
    localparam logic [1:0] PLIC_PENDING = 2'd1;
    localparam logic [1:0] PLIC_CLAIM   = 2'd2;

    // Only one source, so a claim returns this or zero
    localparam logic [DATA_W-1:0] PLIC_SRC_ID = 32'd1;

    //////////////////////////////////////////////////////////////////////
    // Bus address as seen by the decoder or by a peripheral
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [REGION_W-1:0] region;
        logic [OFFSET_W-1:0] offset;
    } addr_region_t;

    typedef struct packed {
        logic [27:0] upper;
        logic [1:0]  word_idx;
        logic [1:0]  byte_off;
    } addr_reg_t;

    typedef union packed {
        addr_region_t region_view;
        addr_reg_t    reg_view;
    } bus_addr_u;

endpackage

`default_nettype wire
